//--- design/rename_cfg.svh
// rename configuration macros

`ifndef RENAME_CFG_SVH
`define RENAME_CFG_SVH

//////////////////////////////////////////////////////////////////////
// sizes
//////////////////////////////////////////////////////////////////////

// architectural registers, power of two
`define RENAME_ARCH_REGS 32

// reorder buffer entries, power of two
`define RENAME_ROB_DEPTH 16

//////////////////////////////////////////////////////////////////////
// derived widths
//////////////////////////////////////////////////////////////////////

`define RENAME_REG_BITS $clog2(`RENAME_ARCH_REGS)
`define RENAME_ROB_BITS $clog2(`RENAME_ROB_DEPTH)

// value lives in the register file
// only the top bit of the tag is set
`define RENAME_ZERO_TAG {1'b1, {`RENAME_ROB_BITS{1'b0}}}

`endif

//--- design/rename_pkg.sv
// rename shared types

`include "rename_cfg.svh"

package rename_pkg;

    //////////////////////////////////////////////////////////////////////
    // index and tag vectors
    //////////////////////////////////////////////////////////////////////

    // architectural register number
    typedef logic [`RENAME_REG_BITS-1:0] reg_idx_t;

    // slot inside the reorder buffer
    typedef logic [`RENAME_ROB_BITS-1:0] rob_idx_t;

    // rename tag
    // top bit clear -> rob slot in the low bits
    // top bit set -> register file sentinel
    typedef logic [`RENAME_ROB_BITS:0] rob_tag_t;

    //////////////////////////////////////////////////////////////////////
    // rob occupancy
    //////////////////////////////////////////////////////////////////////

    // head == tail is ambiguous, so the state tells empty from full
    typedef enum logic [1:0] {
        rob_empty,
        rob_partial,
        rob_full
    } rob_state_t;

endpackage

//--- design/map_table.sv
// register rename map table

`timescale 1ns/1ps

`include "rename_cfg.svh"

module map_table (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 squash,
    // dispatch side
    input  logic                 dispatch_enable,
    input  rename_pkg::reg_idx_t dispatch_rd,
    input  rename_pkg::rob_tag_t alloc_tag,
    input  rename_pkg::reg_idx_t dispatch_rs1,
    input  rename_pkg::reg_idx_t dispatch_rs2,
    // retire side
    input  logic                 retire_valid,
    input  rename_pkg::reg_idx_t retire_rd,
    input  rename_pkg::rob_tag_t retire_tag,
    input  logic                 retire_has_dest,
    // completion broadcast
    input  logic                 cdb_valid,
    input  rename_pkg::rob_tag_t cdb_tag,
    // source lookups
    output rename_pkg::rob_tag_t rs1_tag,
    output logic                 rs1_ready,
    output rename_pkg::rob_tag_t rs2_tag,
    output logic                 rs2_ready
);

    //////////////////////////////////////////////////////////////////////
    // state
    //////////////////////////////////////////////////////////////////////

    // producer tag per register
    rename_pkg::rob_tag_t map_tag      [`RENAME_ARCH_REGS];
    rename_pkg::rob_tag_t map_tag_next [`RENAME_ARCH_REGS];

    // producer has completed, value sits in the rob
    logic [`RENAME_ARCH_REGS-1:0] map_ready;
    logic [`RENAME_ARCH_REGS-1:0] map_ready_next;

    // retire only clears a mapping nobody renamed since
    logic retire_clears;

    // broadcast counts this cycle
    logic cdb_live;

    // per source bypass hits
    logic rs1_retired;
    logic rs2_retired;
    logic rs1_woken;
    logic rs2_woken;

    assign retire_clears = retire_valid && retire_has_dest &&
                           (map_tag[retire_rd] == retire_tag);

    // squash drops the broadcast, sentinel never wakes anything
    assign cdb_live = cdb_valid && !squash && !cdb_tag[`RENAME_ROB_BITS];

    //////////////////////////////////////////////////////////////////////
    // next state
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        map_tag_next   = map_tag;
        map_ready_next = map_ready;

        // retire clear first
        if (retire_clears) begin
            map_tag_next[retire_rd]   = `RENAME_ZERO_TAG;
            map_ready_next[retire_rd] = 1'b0;
        end

        // wakeup on the post-retire tags
        // a freshly cleared sentinel cannot match
        if (cdb_live) begin
            for (int i = 0; i < `RENAME_ARCH_REGS; i++) begin
                if (map_tag_next[i] == cdb_tag) begin
                    map_ready_next[i] = 1'b1;
                end
            end
        end

        // new mapping wins over both
        // r0 is hardwired, never renamed
        if (dispatch_enable && (dispatch_rd != '0)) begin
            map_tag_next[dispatch_rd]   = alloc_tag;
            map_ready_next[dispatch_rd] = 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            // everything back to the register file
            for (int i = 0; i < `RENAME_ARCH_REGS; i++) begin
                map_tag[i] <= `RENAME_ZERO_TAG;
            end
            map_ready <= '0;
        end else begin
            map_tag   <= map_tag_next;
            map_ready <= map_ready_next;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // source lookup
    //////////////////////////////////////////////////////////////////////

    // registered state only, so rd == rs still sees the old producer
    assign rs1_retired = retire_clears && (retire_rd == dispatch_rs1);
    assign rs2_retired = retire_clears && (retire_rd == dispatch_rs2);

    assign rs1_woken = cdb_live && (map_tag[dispatch_rs1] == cdb_tag);
    assign rs2_woken = cdb_live && (map_tag[dispatch_rs2] == cdb_tag);

    // retiring producer -> read from the register file
    assign rs1_tag = rs1_retired ? `RENAME_ZERO_TAG : map_tag[dispatch_rs1];
    assign rs2_tag = rs2_retired ? `RENAME_ZERO_TAG : map_tag[dispatch_rs2];

    assign rs1_ready = !rs1_retired && (map_ready[dispatch_rs1] || rs1_woken);
    assign rs2_ready = !rs2_retired && (map_ready[dispatch_rs2] || rs2_woken);

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    a_zero_reg_sentinel: assert property (
        @(posedge clock) disable iff (reset)
        map_tag[0] == `RENAME_ZERO_TAG
    ) else $error("map_table: r0 picked up a rob tag");

    // ready only means something for a rob producer
    for (genvar r = 0; r < `RENAME_ARCH_REGS; r++) begin : g_ready_check
        a_ready_not_sentinel: assert property (
            @(posedge clock) disable iff (reset)
            map_ready[r] |-> !map_tag[r][`RENAME_ROB_BITS]
        ) else $error("map_table: ready set on sentinel, reg %0d", r);
    end

endmodule

//--- design/reorder_buffer.sv
// reorder buffer tag allocator

`timescale 1ns/1ps

`include "rename_cfg.svh"

module reorder_buffer (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 squash,
    // dispatch
    input  logic                 dispatch_valid,
    input  rename_pkg::reg_idx_t dispatch_rd,
    // completion broadcast
    input  logic                 cdb_valid,
    input  rename_pkg::rob_tag_t cdb_tag,
    // allocation
    output logic                 dispatch_enable,
    output logic                 dispatch_ready,
    output rename_pkg::rob_tag_t alloc_tag,
    // retire
    output logic                 retire_valid,
    output rename_pkg::rob_tag_t retire_tag,
    output rename_pkg::reg_idx_t retire_rd,
    output logic                 retire_has_dest
);

    //////////////////////////////////////////////////////////////////////
    // pointers and entries
    //////////////////////////////////////////////////////////////////////

    // oldest live entry
    rename_pkg::rob_idx_t   head;
    // next slot to hand out
    rename_pkg::rob_idx_t   tail;
    rename_pkg::rob_state_t state;

    rename_pkg::rob_idx_t   head_next;
    rename_pkg::rob_idx_t   tail_next;
    rename_pkg::rob_state_t state_next;

    // destination register per entry
    rename_pkg::reg_idx_t entry_rd [`RENAME_ROB_DEPTH];

    // completion seen on the cdb
    logic [`RENAME_ROB_DEPTH-1:0] entry_done;

    // slot named by the broadcast
    rename_pkg::rob_idx_t cdb_idx;

    assign cdb_idx = cdb_tag[`RENAME_ROB_BITS-1:0];

    //////////////////////////////////////////////////////////////////////
    // dispatch and retire handshake
    //////////////////////////////////////////////////////////////////////

    // full or squashing -> nothing gets in
    assign dispatch_ready  = (state != rename_pkg::rob_full) && !squash;
    assign dispatch_enable = dispatch_valid && dispatch_ready;

    // slot tags always have the top bit clear
    assign alloc_tag = {1'b0, tail};

    // head retires once its completion is registered
    assign retire_valid    = !squash && (state != rename_pkg::rob_empty) && entry_done[head];
    assign retire_tag      = {1'b0, head};
    assign retire_rd       = entry_rd[head];
    assign retire_has_dest = (entry_rd[head] != '0);

    //////////////////////////////////////////////////////////////////////
    // occupancy
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        head_next  = retire_valid ? head + 1'b1 : head;
        tail_next  = dispatch_enable ? tail + 1'b1 : tail;
        state_next = state;

        // alloc and retire together keep the count
        if (dispatch_enable && !retire_valid) begin
            if (tail_next == head) begin
                state_next = rename_pkg::rob_full;
            end else begin
                state_next = rename_pkg::rob_partial;
            end
        end else if (retire_valid && !dispatch_enable) begin
            if (head_next == tail) begin
                state_next = rename_pkg::rob_empty;
            end else begin
                state_next = rename_pkg::rob_partial;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            head       <= '0;
            tail       <= '0;
            state      <= rename_pkg::rob_empty;
            entry_done <= '0;
        end else begin
            head  <= head_next;
            tail  <= tail_next;
            state <= state_next;
            if (cdb_valid) begin
                entry_done[cdb_idx] <= 1'b1;
            end
            // new entry starts incomplete
            if (dispatch_enable) begin
                entry_done[tail] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (dispatch_enable) begin
            entry_rd[tail] <= dispatch_rd;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    // slot between head and tail, wrap aware
    function automatic logic entry_live(rename_pkg::rob_idx_t idx);
        logic after_head;
        logic before_tail;
        after_head  = (idx >= head);
        before_tail = (idx < tail);
        case (state)
            rename_pkg::rob_empty: return 1'b0;
            rename_pkg::rob_full:  return 1'b1;
            default: begin
                if (tail > head) begin
                    return after_head && before_tail;
                end
                return after_head || before_tail;
            end
        endcase
    endfunction

    // a new entry never lands on a slot still in flight
    a_no_alloc_when_full: assert property (
        @(posedge clock) disable iff (reset)
        dispatch_enable |-> !entry_live(tail)
    ) else $error("reorder_buffer: allocation while full");

    a_cdb_names_live: assert property (
        @(posedge clock) disable iff (reset)
        cdb_valid && !squash |-> !cdb_tag[`RENAME_ROB_BITS] && entry_live(cdb_idx)
    ) else $error("reorder_buffer: cdb tag %0h not in flight", cdb_tag);

    // pointers must agree with the state on every retire
    a_no_retire_empty: assert property (
        @(posedge clock) disable iff (reset)
        retire_valid |-> (head != tail) || (state == rename_pkg::rob_full)
    ) else $error("reorder_buffer: retire from an empty buffer");

endmodule

//--- design/rename_top.sv
// register rename front end

`timescale 1ns/1ps

module rename_top (
    input  logic                 clock,
    input  logic                 reset,
    // dispatch
    input  logic                 dispatch_valid,
    input  rename_pkg::reg_idx_t dispatch_rd,
    input  rename_pkg::reg_idx_t dispatch_rs1,
    input  rename_pkg::reg_idx_t dispatch_rs2,
    output logic                 dispatch_ready,
    output rename_pkg::rob_tag_t dispatch_tag,
    // source lookups
    output rename_pkg::rob_tag_t rs1_tag,
    output logic                 rs1_ready,
    output rename_pkg::rob_tag_t rs2_tag,
    output logic                 rs2_ready,
    // completion and flush
    input  logic                 cdb_valid,
    input  rename_pkg::rob_tag_t cdb_tag,
    input  logic                 squash,
    // retire
    output logic                 retire_valid,
    output rename_pkg::rob_tag_t retire_tag,
    output rename_pkg::reg_idx_t retire_rd,
    output logic                 retire_has_dest
);

    // accepted dispatch, gated inside the rob
    logic                 dispatch_enable;
    // tag handed to the dispatching instruction
    rename_pkg::rob_tag_t alloc_tag;

    assign dispatch_tag = alloc_tag;

    //////////////////////////////////////////////////////////////////////
    // allocation and retire order
    //////////////////////////////////////////////////////////////////////

    reorder_buffer u_reorder_buffer (
        .clock           (clock),
        .reset           (reset),
        .squash          (squash),
        .dispatch_valid  (dispatch_valid),
        .dispatch_rd     (dispatch_rd),
        .cdb_valid       (cdb_valid),
        .cdb_tag         (cdb_tag),
        .dispatch_enable (dispatch_enable),
        .dispatch_ready  (dispatch_ready),
        .alloc_tag       (alloc_tag),
        .retire_valid    (retire_valid),
        .retire_tag      (retire_tag),
        .retire_rd       (retire_rd),
        .retire_has_dest (retire_has_dest)
    );

    //////////////////////////////////////////////////////////////////////
    // mapping and lookup
    //////////////////////////////////////////////////////////////////////

    map_table u_map_table (
        .clock           (clock),
        .reset           (reset),
        .squash          (squash),
        .dispatch_enable (dispatch_enable),
        .dispatch_rd     (dispatch_rd),
        .alloc_tag       (alloc_tag),
        .dispatch_rs1    (dispatch_rs1),
        .dispatch_rs2    (dispatch_rs2),
        .retire_valid    (retire_valid),
        .retire_rd       (retire_rd),
        .retire_tag      (retire_tag),
        .retire_has_dest (retire_has_dest),
        .cdb_valid       (cdb_valid),
        .cdb_tag         (cdb_tag),
        .rs1_tag         (rs1_tag),
        .rs1_ready       (rs1_ready),
        .rs2_tag         (rs2_tag),
        .rs2_ready       (rs2_ready)
    );

endmodule

//--- sim/tb_rename_top.sv
// rename front end testbench

`timescale 1ns/1ps

`include "rename_cfg.svh"

module tb_rename_top;

    localparam int REGS        = `RENAME_ARCH_REGS;
    localparam int DEPTH       = `RENAME_ROB_DEPTH;
    localparam int CYCLE_LIMIT = 2000;
    localparam rename_pkg::rob_tag_t ZERO_TAG = `RENAME_ZERO_TAG;

    logic                 clock;
    logic                 reset;
    logic                 dispatch_valid;
    rename_pkg::reg_idx_t dispatch_rd;
    rename_pkg::reg_idx_t dispatch_rs1;
    rename_pkg::reg_idx_t dispatch_rs2;
    logic                 dispatch_ready;
    rename_pkg::rob_tag_t dispatch_tag;
    rename_pkg::rob_tag_t rs1_tag;
    logic                 rs1_ready;
    rename_pkg::rob_tag_t rs2_tag;
    logic                 rs2_ready;
    logic                 cdb_valid;
    rename_pkg::rob_tag_t cdb_tag;
    logic                 squash;
    logic                 retire_valid;
    rename_pkg::rob_tag_t retire_tag;
    rename_pkg::reg_idx_t retire_rd;
    logic                 retire_has_dest;

    // reference model with the outstanding entries oldest first
    rename_pkg::rob_tag_t ref_map [REGS];
    logic                 ref_ready [REGS];
    rename_pkg::rob_tag_t q_tag [$];
    rename_pkg::reg_idx_t q_rd [$];
    logic                 q_done [$];
    rename_pkg::rob_idx_t ref_tail;

    int errors;
    int checks;
    int cycles;
    // two distinct destinations shared by the early tests
    int reg_a;
    int reg_b;

    rename_top u_rename_top (.*);

    always #10 clock = ~clock;

    // ends a hung run
    always @(posedge clock) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: tests still running after %0d cycles", CYCLE_LIMIT);
            $display("checks: %0d, errors: %0d", checks, errors);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checking and reference model
    //////////////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("error at %0t: %s expected %0h got %0h", $time, name, expected, actual);
        end
    endtask

    // retiring producer sends the source back to the register file
    function automatic logic [31:0] model_tag(rename_pkg::reg_idx_t rs, logic clears);
        if (clears && rs == q_rd[0]) begin
            return 32'(ZERO_TAG);
        end
        return 32'(ref_map[rs]);
    endfunction

    function automatic logic [31:0] model_ready(rename_pkg::reg_idx_t rs, logic clears);
        logic woken;
        woken = cdb_valid && !squash && !cdb_tag[`RENAME_ROB_BITS] && ref_map[rs] == cdb_tag;
        if (clears && rs == q_rd[0]) begin
            return 0;
        end
        return 32'(ref_ready[rs] || woken);
    endfunction

    task automatic clear_model();
        for (int r = 0; r < REGS; r++) begin
            ref_map[r]   = ZERO_TAG;
            ref_ready[r] = 1'b0;
        end
        q_tag.delete();
        q_rd.delete();
        q_done.delete();
        ref_tail = '0;
    endtask

    // all outputs against the model at the falling edge, then one clock
    task automatic tick();
        logic retire;
        logic clears;
        logic accept;
        @(negedge clock);
        retire = !squash && q_tag.size() > 0 && q_done[0];
        clears = retire && q_rd[0] != '0 && ref_map[q_rd[0]] == q_tag[0];
        accept = dispatch_valid && !squash && q_tag.size() < DEPTH;
        check_value("dispatch_ready", 32'(!squash && q_tag.size() < DEPTH), 32'(dispatch_ready));
        check_value("dispatch_tag", 32'(ref_tail), 32'(dispatch_tag));
        check_value("rs1_tag", model_tag(dispatch_rs1, clears), 32'(rs1_tag));
        check_value("rs1_ready", model_ready(dispatch_rs1, clears), 32'(rs1_ready));
        check_value("rs2_tag", model_tag(dispatch_rs2, clears), 32'(rs2_tag));
        check_value("rs2_ready", model_ready(dispatch_rs2, clears), 32'(rs2_ready));
        check_value("retire_valid", 32'(retire), 32'(retire_valid));
        if (retire) begin
            check_value("retire_tag", 32'(q_tag[0]), 32'(retire_tag));
            check_value("retire_rd", 32'(q_rd[0]), 32'(retire_rd));
            check_value("retire_has_dest", 32'(q_rd[0] != '0), 32'(retire_has_dest));
        end
        @(posedge clock);
        if (squash) begin
            clear_model();
        end else begin
            // retire clear first, then wakeup, then new mapping
            if (clears) begin
                ref_map[q_rd[0]]   = ZERO_TAG;
                ref_ready[q_rd[0]] = 1'b0;
            end
            if (retire) begin
                void'(q_tag.pop_front());
                void'(q_rd.pop_front());
                void'(q_done.pop_front());
            end
            if (cdb_valid && !cdb_tag[`RENAME_ROB_BITS]) begin
                for (int r = 0; r < REGS; r++) begin
                    if (ref_map[r] == cdb_tag) begin
                        ref_ready[r] = 1'b1;
                    end
                end
                foreach (q_tag[i]) begin
                    if (q_tag[i] == cdb_tag) begin
                        q_done[i] = 1'b1;
                    end
                end
            end
            if (accept) begin
                q_tag.push_back({1'b0, ref_tail});
                q_rd.push_back(dispatch_rd);
                q_done.push_back(1'b0);
                if (dispatch_rd != '0) begin
                    ref_map[dispatch_rd]   = {1'b0, ref_tail};
                    ref_ready[dispatch_rd] = 1'b0;
                end
                ref_tail = ref_tail + 1'b1;
            end
        end
        #1;
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus helpers
    //////////////////////////////////////////////////////////////////////

    task automatic set_dispatch(input logic valid, input int rd, input int rs1, input int rs2);
        dispatch_valid = valid;
        dispatch_rd    = rename_pkg::reg_idx_t'(rd);
        dispatch_rs1   = rename_pkg::reg_idx_t'(rs1);
        dispatch_rs2   = rename_pkg::reg_idx_t'(rs2);
    endtask

    task automatic set_cdb(input logic valid, input int tag);
        cdb_valid = valid;
        cdb_tag   = rename_pkg::rob_tag_t'(tag);
    endtask

    // any register but r0
    function automatic int pick_reg();
        return 1 + int'($urandom % (REGS - 1));
    endfunction

    // every register back in the register file, nothing to retire
    task automatic check_all_unmapped();
        for (int r = 0; r < REGS; r += 2) begin
            set_dispatch(1'b0, 0, r, r + 1);
            #5;
            check_value("rs1_tag", 32'(ZERO_TAG), 32'(rs1_tag));
            check_value("rs1_ready", 0, 32'(rs1_ready));
            check_value("rs2_tag", 32'(ZERO_TAG), 32'(rs2_tag));
            check_value("rs2_ready", 0, 32'(rs2_ready));
            check_value("dispatch_ready", 1, 32'(dispatch_ready));
            check_value("retire_valid", 0, 32'(retire_valid));
            tick();
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic test_reset_state();
        check_all_unmapped();
    endtask

    task automatic test_dispatch_chain();
        reg_a = pick_reg();
        reg_b = reg_a;
        while (reg_b == reg_a) begin
            reg_b = pick_reg();
        end
        set_dispatch(1'b1, reg_a, 0, 0);
        #5;
        check_value("dispatch_tag", 0, 32'(dispatch_tag));
        tick();
        // b consumes a from its producer
        set_dispatch(1'b1, reg_b, reg_a, reg_a);
        #5;
        check_value("dispatch_tag", 1, 32'(dispatch_tag));
        check_value("rs1_tag", 0, 32'(rs1_tag));
        check_value("rs1_ready", 0, 32'(rs1_ready));
        tick();
        // a renamed while reading itself
        set_dispatch(1'b1, reg_a, reg_a, reg_b);
        #5;
        check_value("dispatch_tag", 2, 32'(dispatch_tag));
        check_value("rs1_tag", 0, 32'(rs1_tag));
        check_value("rs2_tag", 1, 32'(rs2_tag));
        tick();
        // r0 destination takes a slot but no mapping
        set_dispatch(1'b1, 0, reg_a, 0);
        #5;
        check_value("dispatch_tag", 3, 32'(dispatch_tag));
        check_value("rs1_tag", 2, 32'(rs1_tag));
        tick();
        set_dispatch(1'b0, 0, 0, reg_a);
        #5;
        check_value("rs1_tag", 32'(ZERO_TAG), 32'(rs1_tag));
        check_value("rs2_tag", 2, 32'(rs2_tag));
        tick();
    endtask

    task automatic test_cdb_wakeup();
        // tag 1 produces b
        set_dispatch(1'b0, 0, reg_b, reg_a);
        set_cdb(1'b1, 1);
        #5;
        check_value("rs1_ready", 1, 32'(rs1_ready));
        check_value("rs2_ready", 0, 32'(rs2_ready));
        tick();
        set_cdb(1'b0, 0);
        #5;
        check_value("rs1_ready", 1, 32'(rs1_ready));
        tick();
        // tag 0 was a's first producer, a now waits on tag 2
        set_dispatch(1'b0, 0, reg_a, reg_b);
        set_cdb(1'b1, 0);
        #5;
        check_value("rs1_tag", 2, 32'(rs1_tag));
        check_value("rs1_ready", 0, 32'(rs1_ready));
        tick();
        set_cdb(1'b0, 0);
    endtask

    task automatic test_in_order_retire();
        // head retires, a was renamed so it keeps tag 2
        #5;
        check_value("retire_valid", 1, 32'(retire_valid));
        check_value("retire_tag", 0, 32'(retire_tag));
        check_value("retire_rd", reg_a, 32'(retire_rd));
        check_value("rs1_tag", 2, 32'(rs1_tag));
        tick();
        #5;
        check_value("retire_tag", 1, 32'(retire_tag));
        check_value("rs2_tag", 32'(ZERO_TAG), 32'(rs2_tag));
        tick();
        // younger entry completes first
        set_cdb(1'b1, 3);
        tick();
        set_cdb(1'b1, 2);
        #5;
        check_value("retire_valid", 0, 32'(retire_valid));
        tick();
        set_cdb(1'b0, 0);
        #5;
        check_value("retire_tag", 2, 32'(retire_tag));
        check_value("retire_has_dest", 1, 32'(retire_has_dest));
        check_value("rs1_tag", 32'(ZERO_TAG), 32'(rs1_tag));
        tick();
        #5;
        check_value("retire_tag", 3, 32'(retire_tag));
        check_value("retire_has_dest", 0, 32'(retire_has_dest));
        tick();
    endtask

    task automatic test_rob_full();
        int blocked_rd;
        for (int n = 0; n < DEPTH; n++) begin
            set_dispatch(1'b1, pick_reg(), 0, 0);
            #5;
            check_value("dispatch_tag", (n + 4) % DEPTH, 32'(dispatch_tag));
            tick();
        end
        // dropped, lookup next cycle still shows the old mapping
        blocked_rd = pick_reg();
        set_dispatch(1'b1, blocked_rd, blocked_rd, 0);
        #5;
        check_value("dispatch_ready", 0, 32'(dispatch_ready));
        tick();
        set_dispatch(1'b0, 0, blocked_rd, 0);
        set_cdb(1'b1, 4);
        tick();
        set_cdb(1'b0, 0);
        #5;
        check_value("retire_valid", 1, 32'(retire_valid));
        check_value("dispatch_ready", 0, 32'(dispatch_ready));
        tick();
        set_dispatch(1'b1, blocked_rd, 0, 0);
        #5;
        check_value("dispatch_ready", 1, 32'(dispatch_ready));
        check_value("dispatch_tag", 4, 32'(dispatch_tag));
        tick();
        set_dispatch(1'b0, 0, 0, 0);
    endtask

    task automatic test_squash();
        // head is tag 5, complete it so only squash holds retire back
        set_cdb(1'b1, 5);
        tick();
        set_dispatch(1'b1, pick_reg(), 0, 0);
        set_cdb(1'b1, 6);
        squash = 1'b1;
        #5;
        check_value("dispatch_ready", 0, 32'(dispatch_ready));
        check_value("retire_valid", 0, 32'(retire_valid));
        tick();
        squash = 1'b0;
        set_cdb(1'b0, 0);
        check_all_unmapped();
        set_dispatch(1'b1, pick_reg(), 0, 0);
        #5;
        check_value("dispatch_tag", 0, 32'(dispatch_tag));
        tick();
        set_dispatch(1'b0, 0, 0, 0);
    endtask

    initial begin
        clock  = 1'b0;
        reset  = 1'b1;
        squash = 1'b0;
        set_dispatch(1'b0, 0, 0, 0);
        set_cdb(1'b0, 0);
        void'($urandom(32'hbca051a6));
        clear_model();
        repeat (2) @(posedge clock);
        #1;
        reset = 1'b0;
        test_reset_state();
        test_dispatch_chain();
        test_cdb_wakeup();
        test_in_order_retire();
        test_rob_full();
        test_squash();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+design
design/rename_pkg.sv
design/map_table.sv
design/reorder_buffer.sv
design/rename_top.sv
sim/tb_rename_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_rename_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= PASS: all tests

SOURCES := $(wildcard design/*.sv design/*.svh sim/*.sv)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, search $(LOG) for the pass line"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG) && echo "result: pass" || (echo "result: fail"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
